// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - .

sources:
  - files:
      - mem_types_pkg.sv
      - line_buffer.sv
      - cache_arbiter.sv
      - cacheline_adaptor.sv
      - mem_subsystem.sv
  - target: test
    files:
      - mem_assertions.sv
      - mem_checker.sv
      - tb_mem_subsystem.sv

// ==== cache_arbiter.sv ====
`default_nettype none

module cache_arbiter
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,

    input  line_req_t ireq_i,      // instruction buffer
    output line_t     irdata_o,
    output logic      iresp_o,

    input  line_req_t dreq_i,      // data buffer
    output line_t     drdata_o,
    output logic      dresp_o,

    output line_req_t mem_req_o,   // cacheline adaptor
    input  line_t     mem_rdata_i,
    input  logic      mem_resp_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DATA,
        ARB_INST
    } arb_e;

    arb_e state_q;
    arb_e state_d;
    logic ireq_act;
    logic dreq_act;

    assign ireq_act = ireq_i.read || ireq_i.write;
    assign dreq_act = dreq_i.read || dreq_i.write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (dreq_act) begin
                    state_d = ARB_DATA;   // data side wins a tie
                end else if (ireq_act) begin
                    state_d = ARB_INST;
                end
            end
            ARB_DATA, ARB_INST: begin
                // grant held until the whole line is done
                if (mem_resp_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // forward only the owner's request
    always_comb begin
        case (state_q)
            ARB_DATA: mem_req_o = dreq_i;
            ARB_INST: mem_req_o = ireq_i;
            default:  mem_req_o = '0;
        endcase
    end

    // resp and data steered back to the owner
    assign dresp_o  = (state_q == ARB_DATA) && mem_resp_i;
    assign iresp_o  = (state_q == ARB_INST) && mem_resp_i;
    assign drdata_o = (state_q == ARB_DATA) ? mem_rdata_i : '0;
    assign irdata_o = (state_q == ARB_INST) ? mem_rdata_i : '0;

endmodule : cache_arbiter

`default_nettype wire

// ==== cacheline_adaptor.sv ====
`default_nettype none
`include "mem_config.svh"

module cacheline_adaptor
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,

    // line side from the arbiter
    input  line_req_t line_req_i,
    output line_t     line_o,
    output logic      resp_o,

    // burst memory side
    input  burst_t    burst_i,
    output burst_t    burst_o,
    output addr_t     address_o,
    output logic      read_o,
    output logic      write_o,
    input  logic      resp_i
);

    localparam int BEAT_W = $clog2(`BEATS);

    typedef enum logic [1:0] {
        A_IDLE,
        A_READ,
        A_WRITE,
        A_DONE    // line complete and resp to the arbiter
    } adp_e;

    adp_e              state_q;
    logic [BEAT_W-1:0] beat_q;
    addr_t             addr_q;
    line_t             data_q;   // write source or read assembly
    logic              start;
    logic              last_beat;

    assign start     = (state_q == A_IDLE) && (line_req_i.read || line_req_i.write);
    assign last_beat = resp_i && (beat_q == BEAT_W'(`BEATS - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= A_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                A_IDLE: begin
                    beat_q <= '0;
                    if (start) begin
                        state_q <= line_req_i.read ? A_READ : A_WRITE;
                    end
                end
                A_READ, A_WRITE: begin
                    if (resp_i) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= A_DONE;
                    end
                end
                A_DONE: state_q <= A_IDLE;
                default: state_q <= A_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= line_req_i.addr;   // line channel carries an aligned address
            data_q <= line_req_i.wdata;
        end else if ((state_q == A_READ) && resp_i) begin
            data_q[beat_q*`BURST_BITS +: `BURST_BITS] <= burst_i;  // beat k at 64k
        end
    end

    assign address_o = addr_q;   // stable for the whole transfer
    assign read_o    = (state_q == A_READ);
    assign write_o   = (state_q == A_WRITE);
    assign burst_o   = data_q[beat_q*`BURST_BITS +: `BURST_BITS];
    assign line_o    = data_q;
    assign resp_o    = (state_q == A_DONE);

endmodule : cacheline_adaptor

`default_nettype wire

// ==== files.f ====
+incdir+.
mem_types_pkg.sv
line_buffer.sv
cache_arbiter.sv
cacheline_adaptor.sv
mem_subsystem.sv
mem_assertions.sv
mem_checker.sv
tb_mem_subsystem.sv

// ==== line_buffer.sv ====
`default_nettype none
`include "mem_config.svh"

module line_buffer
    import mem_types_pkg::*;
#(
    parameter bit WRITABLE = 1'b1
) (
    input  logic      clk,
    input  logic      reset_i,
    input  word_req_t req_i,
    output word_t     rdata_o,
    output logic      resp_o,
    output line_req_t line_req_o,
    input  line_t     line_rdata_i,
    input  logic      line_resp_i
);

    localparam int TAG_BITS = `ADDR_BITS - `OFFSET_BITS;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WB,     // old line going back to memory
        S_FILL,
        S_DONE    // resp cycle, port request still held
    } state_e;

    state_e              state_q;
    logic                valid_q;
    logic                dirty_q;
    line_t               line_q;
    logic [TAG_BITS-1:0] tag_q;
    word_t               rdata_q;

    logic [TAG_BITS-1:0] req_tag;
    logic [2:0]          word_idx;
    logic                wr_req;
    logic                active;
    logic                hit_go;
    logic                fill_done;

    function automatic line_t merge_word(input line_t line, input logic [2:0] idx,
                                         input mask_t mask, input word_t wdata);
        line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[idx*`WORD_BITS + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign req_tag   = req_i.addr[`ADDR_BITS-1:`OFFSET_BITS];
    assign word_idx  = req_i.addr[4:2];
    assign wr_req    = WRITABLE && req_i.write;   // always low on the fetch side
    assign active    = req_i.read || wr_req;
    assign hit_go    = (state_q == S_IDLE) && active && valid_q && (tag_q == req_tag);
    assign fill_done = (state_q == S_FILL) && line_resp_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (hit_go) begin
                        dirty_q <= dirty_q || wr_req;
                        state_q <= S_DONE;
                    end else if (active) begin
                        // write back first if the old line was modified
                        state_q <= (valid_q && dirty_q) ? S_WB : S_FILL;
                    end
                end
                S_WB: begin
                    if (line_resp_i) begin
                        state_q <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (line_resp_i) begin
                        valid_q <= 1'b1;
                        dirty_q <= wr_req;  // write miss merges into the fresh line
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hit_go) begin
            rdata_q <= line_q[word_idx*`WORD_BITS +: `WORD_BITS];
            if (wr_req) begin
                line_q <= merge_word(line_q, word_idx, req_i.wmask, req_i.wdata);
            end
        end else if (fill_done) begin
            rdata_q <= line_rdata_i[word_idx*`WORD_BITS +: `WORD_BITS];
            line_q  <= wr_req ? merge_word(line_rdata_i, word_idx, req_i.wmask, req_i.wdata)
                              : line_rdata_i;
            tag_q   <= req_tag;
        end
    end

    assign resp_o  = (state_q == S_DONE);
    assign rdata_o = rdata_q;

    always_comb begin
        line_req_o.read  = (state_q == S_FILL);
        line_req_o.write = (state_q == S_WB);
        line_req_o.wdata = line_q;
        if (state_q == S_WB) begin
            line_req_o.addr = {tag_q, {`OFFSET_BITS{1'b0}}};  // victim address
        end else begin
            line_req_o.addr = {req_tag, {`OFFSET_BITS{1'b0}}};
        end
    end

endmodule : line_buffer

`default_nettype wire

// ==== mem_assertions.sv ====
`default_nettype none
`include "mem_config.svh"

module mem_assertions
    import mem_types_pkg::*;
(
    input logic      clk,
    input logic      reset_i,
    input line_req_t line_req_i,
    input logic      line_resp_i,
    input addr_t     address_i,
    input logic      read_i,
    input logic      write_i,
    input logic      beat_resp_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int   error_count = 0;
    int   beats;            // beats seen in the current transfer
    logic busy;

    assign busy = read_i || write_i;

    always @(posedge clk) begin
        if (reset_i || !busy) begin
            beats <= 0;
        end else if (beat_resp_i) begin
            beats <= beats + 1;
        end
    end

    rw_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(read_i && write_i))
    else begin
        error_count++;
        $error("burst read and write high in the same cycle");
    end

    addr_stable: assert property (@(posedge clk) disable iff (reset_i)
        busy && $past(busy) |-> $stable(address_i))
    else begin
        error_count++;
        $error("burst address changed during a transfer");
    end

    addr_aligned: assert property (@(posedge clk) disable iff (reset_i)
        busy |-> (address_i[`OFFSET_BITS-1:0] == '0))
    else begin
        error_count++;
        $error("burst address not line aligned");
    end

    four_beats: assert property (@(posedge clk) disable iff (reset_i)
        line_resp_i |-> (beats == `BEATS))
    else begin
        error_count++;
        $error("line transfer did not take four beats");
    end

    resp_has_req: assert property (@(posedge clk) disable iff (reset_i)
        line_resp_i |-> (line_req_i.read || line_req_i.write))
    else begin
        error_count++;
        $error("line resp without an active line request");
    end

endmodule : mem_assertions

bind cacheline_adaptor mem_assertions mem_assertions_i (
    .clk(clk), .reset_i(reset_i),
    .line_req_i(line_req_i), .line_resp_i(resp_o),
    .address_i(address_o), .read_i(read_o), .write_i(write_o),
    .beat_resp_i(resp_i)
);

`default_nettype wire

// ==== mem_checker.sv ====
`default_nettype none
`include "mem_config.svh"

module mem_checker
    import mem_types_pkg::*;
#(
    parameter word_t FILL_XOR = 32'h0
) (
    input  logic      clk,
    input  logic      reset_i,
    input  word_req_t imem_req_i,
    input  word_t     imem_rdata_i,
    input  logic      imem_resp_i,
    input  word_req_t dmem_req_i,
    input  word_t     dmem_rdata_i,
    input  logic      dmem_resp_i,
    input  addr_t     bmem_address_i,
    input  logic      bmem_read_i,
    input  logic      bmem_write_i,
    output int        n_pass_o,
    output int        n_fail_o
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t shadow [addr_t];   // words the data port has written
    logic  seen_req;
    logic  both_wait;         // both ports just started and no burst yet
    logic  xfer_q;
    logic  i_act_q;
    logic  d_act_q;

    function automatic word_t expected_word(input addr_t a);
        return shadow.exists(a) ? shadow[a] : (a ^ FILL_XOR);
    endfunction

    task automatic report(input string msg);
        n_fail_o++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic check_read(input string port, input word_req_t req, input word_t rdata);
        addr_t a;
        word_t exp;
        a   = {req.addr[`ADDR_BITS-1:2], 2'b00};
        exp = expected_word(a);
        if (rdata === exp) begin
            n_pass_o++;
            $display("%0d ns  %s read  %08h -> %08h ok", $time, port, a, rdata);
        end else begin
            n_fail_o++;
            $display("CHECK FAILED at %0d ns: %s read %08h returned %08h, expected %08h",
                     $time, port, a, rdata, exp);
        end
    endtask

    task automatic record_write(input word_req_t req);
        addr_t a;
        word_t w;
        a = {req.addr[`ADDR_BITS-1:2], 2'b00};
        w = expected_word(a);
        for (int b = 0; b < 4; b++) begin
            if (req.wmask[b]) w[b*8 +: 8] = req.wdata[b*8 +: 8];  // only masked lanes
        end
        shadow[a] = w;
        n_pass_o++;
        $display("%0d ns  dmem write %08h mask %04b -> %08h", $time, a, req.wmask, w);
    endtask

    // sampled mid-cycle away from the edges
    always @(negedge clk) begin : watch
        logic xfer;
        logic i_act;
        logic d_act;
        xfer  = bmem_read_i || bmem_write_i;
        i_act = imem_req_i.read;
        d_act = dmem_req_i.read || dmem_req_i.write;
        if (reset_i) begin
            n_pass_o  = 0;
            n_fail_o  = 0;
            seen_req  = 1'b0;
            both_wait = 1'b0;
        end else begin
            if (xfer && !seen_req) report("memory transfer started with no port request");
            if (xfer && !xfer_q && both_wait) begin
                both_wait = 1'b0;
                if (bmem_address_i[`ADDR_BITS-1:`OFFSET_BITS] ==
                    imem_req_i.addr[`ADDR_BITS-1:`OFFSET_BITS]) begin
                    report("instruction line went to memory before the data line");
                end
            end
            if (i_act && d_act && !i_act_q && !d_act_q) both_wait = 1'b1;
            seen_req = seen_req || i_act || d_act;
            if (imem_resp_i) check_read("imem", imem_req_i, imem_rdata_i);
            if (dmem_resp_i) begin
                if (dmem_req_i.write) record_write(dmem_req_i);
                else check_read("dmem", dmem_req_i, dmem_rdata_i);
            end
        end
        xfer_q  = xfer;
        i_act_q = i_act;
        d_act_q = d_act;
    end

endmodule : mem_checker

`default_nettype wire

// ==== mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// one cacheline, eight words
`define LINE_BITS   256
`define WORD_BITS   32

// burst memory side
`define BURST_BITS  64
`define BEATS       4   // beats per line

// byte address
`define ADDR_BITS   32
`define OFFSET_BITS 5   // byte offset inside a line

`endif

// ==== mem_subsystem.sv ====
`default_nettype none

module mem_subsystem
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,

    input  word_req_t imem_req_i,
    output word_t     imem_rdata_o,
    output logic      imem_resp_o,

    input  word_req_t dmem_req_i,
    output word_t     dmem_rdata_o,
    output logic      dmem_resp_o,

    output addr_t     bmem_address_o,
    output logic      bmem_read_o,
    output logic      bmem_write_o,
    input  burst_t    bmem_rdata_i,
    output burst_t    bmem_wdata_o,
    input  logic      bmem_resp_i
);

    // buffer <-> arbiter
    line_req_t ibuf_line_req;
    line_t     ibuf_line_rdata;
    logic      ibuf_line_resp;
    line_req_t dbuf_line_req;
    line_t     dbuf_line_rdata;
    logic      dbuf_line_resp;

    // arbiter <-> adaptor
    line_req_t arb_mem_req;
    line_t     adp_line_rdata;
    logic      adp_line_resp;

    line_buffer #(.WRITABLE(1'b0)) ibuf (  // fetch side, read only
        .clk(clk), .reset_i(reset_i),
        .req_i(imem_req_i), .rdata_o(imem_rdata_o), .resp_o(imem_resp_o),
        .line_req_o(ibuf_line_req), .line_rdata_i(ibuf_line_rdata),
        .line_resp_i(ibuf_line_resp)
    );

    line_buffer #(.WRITABLE(1'b1)) dbuf (
        .clk(clk), .reset_i(reset_i),
        .req_i(dmem_req_i), .rdata_o(dmem_rdata_o), .resp_o(dmem_resp_o),
        .line_req_o(dbuf_line_req), .line_rdata_i(dbuf_line_rdata),
        .line_resp_i(dbuf_line_resp)
    );

    cache_arbiter cache_arbiter (
        .clk(clk), .reset_i(reset_i),
        .ireq_i(ibuf_line_req), .irdata_o(ibuf_line_rdata), .iresp_o(ibuf_line_resp),
        .dreq_i(dbuf_line_req), .drdata_o(dbuf_line_rdata), .dresp_o(dbuf_line_resp),
        .mem_req_o(arb_mem_req), .mem_rdata_i(adp_line_rdata), .mem_resp_i(adp_line_resp)
    );

    cacheline_adaptor cacheline_adaptor (
        .clk(clk), .reset_i(reset_i),
        .line_req_i(arb_mem_req), .line_o(adp_line_rdata), .resp_o(adp_line_resp),
        .burst_i(bmem_rdata_i), .burst_o(bmem_wdata_o), .address_o(bmem_address_o),
        .read_o(bmem_read_o), .write_o(bmem_write_o), .resp_i(bmem_resp_i)
    );

endmodule : mem_subsystem

`default_nettype wire

// ==== mem_types_pkg.sv ====
`default_nettype none
`include "mem_config.svh"

package mem_types_pkg;

    typedef logic [`WORD_BITS-1:0]  word_t;
    typedef logic [`LINE_BITS-1:0]  line_t;   // word k at bits 32k and up
    typedef logic [`BURST_BITS-1:0] burst_t;
    typedef logic [`ADDR_BITS-1:0]  addr_t;
    typedef logic [3:0]             mask_t;   // one bit per byte lane

    // word port request, held until resp
    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        mask_t wmask;
        word_t wdata;
    } word_req_t;

    // line channel request, buffer to arbiter to adaptor
    typedef struct packed {
        addr_t addr;    // line aligned
        logic  read;
        logic  write;
        line_t wdata;
    } line_req_t;

endpackage

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`default_nettype none
`include "mem_config.svh"

module tb_mem_subsystem
    import mem_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD = 100;
    localparam word_t FILL_XOR   = 32'h5a5a_0f0f;   // memory word = its address ^ FILL_XOR
    localparam addr_t I_OFFSET   = 32'h0000_2000;   // fetch line when both ports go at once

    typedef enum logic [1:0] {P_INST, P_DATA, P_BOTH} port_e;

    typedef struct packed {
        port_e port;
        logic  write;
        addr_t addr;
        mask_t wmask;
        word_t wdata;
    } entry_t;

    logic      clk;
    logic      reset;
    word_req_t imem_req;
    word_t     imem_rdata;
    logic      imem_resp;
    word_req_t dmem_req;
    word_t     dmem_rdata;
    logic      dmem_resp;
    addr_t     bmem_address;
    logic      bmem_read;
    logic      bmem_write;
    burst_t    bmem_rdata;
    burst_t    bmem_wdata;
    logic      bmem_resp;
    int        n_pass;
    int        n_fail;

    entry_t    stim[$];
    int        expected_resps = 0;
    logic      table_ready = 1'b0;
    word_t     lcg_state = 32'd94;
    word_t     mem [addr_t];   // only words written by the DUT

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ FILL_XOR);
    endfunction

    task automatic add_entry(input port_e port, input logic write, input addr_t addr,
                             input mask_t wmask);
        entry_t e;
        e.port  = port;
        e.write = write;
        e.addr  = addr;
        e.wmask = wmask;
        e.wdata = write ? lcg_next() : '0;
        stim.push_back(e);
        expected_resps += (port == P_BOTH) ? 2 : 1;
    endtask

    task automatic build_table();
        add_entry(P_INST, 1'b0, 32'h0000_4004, 4'b0000);  // fetch miss
        add_entry(P_INST, 1'b0, 32'h0000_401c, 4'b0000);  // hit, same line
        add_entry(P_DATA, 1'b0, 32'h0000_1008, 4'b0000);  // data miss
        add_entry(P_DATA, 1'b0, 32'h0000_1010, 4'b0000);
        add_entry(P_DATA, 1'b1, 32'h0000_1008, 4'b0101);  // partial write hit
        add_entry(P_DATA, 1'b0, 32'h0000_1008, 4'b0000);  // merged word
        add_entry(P_DATA, 1'b1, 32'h0000_1014, 4'b1111);
        add_entry(P_DATA, 1'b0, 32'h0000_2008, 4'b0000);  // evicts dirty 0x1000 line
        add_entry(P_DATA, 1'b0, 32'h0000_1008, 4'b0000);  // back from memory
        add_entry(P_DATA, 1'b0, 32'h0000_1014, 4'b0000);
        add_entry(P_DATA, 1'b1, 32'h0000_3000, 4'b1100);  // write miss, line now dirty
        add_entry(P_BOTH, 1'b0, 32'h0000_6000, 4'b0000);  // both miss together
        add_entry(P_DATA, 1'b0, 32'h0000_3000, 4'b0000);
        add_entry(P_INST, 1'b0, 32'h0000_8004, 4'b0000);
        add_entry(P_DATA, 1'b0, 32'h0000_6010, 4'b0000);
    endtask

    task automatic apply_entry(input entry_t e);
        word_req_t req;
        logic      i_busy;
        logic      d_busy;
        req.addr  = e.addr;
        req.read  = !e.write;
        req.write = e.write;
        req.wmask = e.wmask;
        req.wdata = e.wdata;
        @(posedge clk);
        #1;
        if (e.port != P_INST) dmem_req = req;
        if (e.port == P_INST) begin
            imem_req = req;
        end else if (e.port == P_BOTH) begin
            imem_req      = req;
            imem_req.addr = e.addr + I_OFFSET;
        end
        i_busy = (e.port != P_DATA);
        d_busy = (e.port != P_INST);
        while (i_busy || d_busy) begin
            @(posedge clk);
            #1;
            if (imem_resp) i_busy = 1'b0;       // resp cycle, drop on the next edge
            else if (!i_busy) imem_req = '0;
            if (dmem_resp) d_busy = 1'b0;
            else if (!d_busy) dmem_req = '0;
        end
        @(posedge clk);
        #1;
        imem_req = '0;
        dmem_req = '0;
    endtask

    mem_subsystem mem_subsystem_i (
        .clk(clk), .reset_i(reset),
        .imem_req_i(imem_req), .imem_rdata_o(imem_rdata), .imem_resp_o(imem_resp),
        .dmem_req_i(dmem_req), .dmem_rdata_o(dmem_rdata), .dmem_resp_o(dmem_resp),
        .bmem_address_o(bmem_address), .bmem_read_o(bmem_read), .bmem_write_o(bmem_write),
        .bmem_rdata_i(bmem_rdata), .bmem_wdata_o(bmem_wdata), .bmem_resp_i(bmem_resp)
    );

    mem_checker #(.FILL_XOR(FILL_XOR)) mem_checker_i (
        .clk(clk), .reset_i(reset),
        .imem_req_i(imem_req), .imem_rdata_i(imem_rdata), .imem_resp_i(imem_resp),
        .dmem_req_i(dmem_req), .dmem_rdata_i(dmem_rdata), .dmem_resp_i(dmem_resp),
        .bmem_address_i(bmem_address), .bmem_read_i(bmem_read), .bmem_write_i(bmem_write),
        .n_pass_o(n_pass), .n_fail_o(n_fail)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // burst memory, each beat answered two cycles after the previous one
    initial begin : burst_memory
        int    wait_cnt;
        int    beat;
        addr_t a;
        wait_cnt   = 0;
        beat       = 0;
        bmem_resp  = 1'b0;
        bmem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            bmem_resp = 1'b0;
            if (bmem_read || bmem_write) begin
                wait_cnt++;
                if (wait_cnt == 2) begin
                    a = bmem_address + addr_t'(beat * 8);
                    if (bmem_write) begin
                        mem[a]          = bmem_wdata[31:0];
                        mem[a + 32'd4]  = bmem_wdata[63:32];
                    end else begin
                        bmem_rdata = {mem_word(a + 32'd4), mem_word(a)};  // low word first
                    end
                    bmem_resp = 1'b1;
                    beat++;
                    wait_cnt = 0;
                end
            end else begin
                wait_cnt = 0;
                beat     = 0;
            end
        end
    end

    initial begin : stimulus
        int total_fail;
        int assert_errors;
        int seen;
        reset    = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (stim[n]) begin
            apply_entry(stim[n]);
        end
        repeat (4) @(posedge clk);
        #1;
        assert_errors = mem_subsystem_i.cacheline_adaptor.mem_assertions_i.error_count;
        seen          = n_pass + n_fail;
        total_fail    = n_fail + assert_errors;
        if (seen != expected_resps) begin
            $display("ERROR: %0d port responses expected but %0d were seen",
                     expected_resps, seen);
            total_fail++;
        end
        $display("tests passed %0d failed %0d (assertion errors %0d)",
                 n_pass, total_fail, assert_errors);
        if (total_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #((stim.size() * 60 + 8) * CLK_PERIOD);
        $display("run timed out: the stimulus table did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule : tb_mem_subsystem

`default_nettype wire
